// File: common/wb_pkg.sv
/* Shared types and constants for the write-back end of the RV32 machine-mode core.
   CSR addresses follow the privileged spec; memory addresses on the data bus are word indices. */
package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  byte_mask_t;

    typedef enum logic [2:0] {ALU, LOAD, STORE, CSR, ECALL, EBREAK, MRET} wb_op_e;

    // Low bits of funct3
    typedef enum logic [1:0] {CSR_RW = 2'd1, CSR_RS = 2'd2, CSR_RC = 2'd3} csr_op_e;

    // funct3[1:0], funct3[2] marks an unsigned load
    typedef enum logic [1:0] {BYTE = 2'd0, HALF = 2'd1, WORD = 2'd2} mem_size_e;

    typedef enum logic [1:0] {IDLE, MEM_WAIT, DONE} wb_state_e;

    // ========================================================================
    // Machine CSR addresses
    // ========================================================================
    localparam csr_addr_t MSTATUS  = 12'h300;
    localparam csr_addr_t MIE      = 12'h304;
    localparam csr_addr_t MTVEC    = 12'h305;
    localparam csr_addr_t MSCRATCH = 12'h340;
    localparam csr_addr_t MEPC     = 12'h341;
    localparam csr_addr_t MCAUSE   = 12'h342;
    localparam csr_addr_t MTVAL    = 12'h343;
    localparam csr_addr_t MIP      = 12'h344;
    localparam csr_addr_t MINSTRET = 12'hB02;

    // Trap causes
    localparam word_t CAUSE_BREAKPOINT = 32'd3;
    localparam word_t CAUSE_ECALL_M    = 32'd11;

endpackage

// File: common/data_bus_if.sv
/* Data memory bus. Master holds req and payload until gnt; a granted read
   returns rdata with rvalid exactly one cycle later. */
`timescale 1ns/10ps

interface data_bus_if import wb_pkg::*; ();

    logic       req;
    logic       we;
    word_t      addr;
    word_t      wdata;
    byte_mask_t mask;
    logic       gnt;
    word_t      rdata;
    logic       rvalid;

    modport master  (output req, we, addr, wdata, mask, input gnt, rdata, rvalid);

    modport slave   (input req, we, addr, wdata, mask, output gnt, rdata, rvalid);

    modport monitor (input req, we, addr, wdata, mask, gnt, rdata, rvalid);

endinterface

// File: design/writeback/wb_stage.sv
/* One instruction in flight at a time; ex_ready is high only in IDLE.
   regwr and branch pulses are registered and come one cycle after accept for non-memory ops. */
`timescale 1ns/10ps

module wb_stage import wb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid,
    output logic      ex_ready,
    input  wb_op_e    ex_op,
    input  word_t     ex_pc,
    input  reg_sel_t  ex_rd,
    input  word_t     ex_addr,
    input  word_t     ex_data,
    input  logic [2:0] ex_funct3,
    output logic      regwr_en,
    output reg_sel_t  regwr_sel,
    output word_t     regwr_data,
    output logic      branch,
    output word_t     branch_target,
    output logic      csr_en,
    output csr_addr_t csr_addr,
    output csr_op_e   csr_op,
    output word_t     csr_operand,
    input  word_t     csr_rdata,
    output logic      trap_ecall,
    output logic      trap_ebreak,
    output logic      trap_mret,
    output word_t     trap_pc,
    output logic      retire,
    input  word_t     mtvec_value,
    input  word_t     mepc_value,
    output logic      ld_req,
    output logic      st_req,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output mem_size_e mem_size,
    output logic      ld_unsigned,
    input  logic      ld_done,
    input  word_t     ld_data,
    input  logic      st_done
);

    wb_state_e  state;
    wb_op_e     op_q;
    word_t      pc_q;
    reg_sel_t   rd_q;
    word_t      addr_q;
    word_t      data_q;
    logic [2:0] funct3_q;
    logic       mem_fin;
    logic       accept;

    assign ex_ready = (state == IDLE);
    assign accept   = ex_valid && ex_ready;

    // Actions decoded from the held instruction
    assign csr_en      = (state == DONE) && (op_q == CSR);
    assign trap_ecall  = (state == DONE) && (op_q == ECALL);
    assign trap_ebreak = (state == DONE) && (op_q == EBREAK);
    assign trap_mret   = (state == DONE) && (op_q == MRET);
    assign csr_addr    = addr_q[11:0];
    assign csr_op      = csr_op_e'(funct3_q[1:0]);
    assign csr_operand = data_q;
    assign trap_pc     = pc_q;

    assign ld_req      = (state == MEM_WAIT) && (op_q == LOAD);
    assign st_req      = (state == MEM_WAIT) && (op_q == STORE);
    assign mem_addr    = addr_q;
    assign mem_wdata   = data_q;
    assign mem_size    = mem_size_e'(funct3_q[1:0]);
    assign ld_unsigned = funct3_q[2];

    assign mem_fin = (op_q == LOAD) ? ld_done : st_done;
    assign retire  = (state == DONE) || ((state == MEM_WAIT) && mem_fin);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            regwr_en <= 1'b0;
            branch   <= 1'b0;
        end else begin
            regwr_en <= 1'b0;
            branch   <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= (ex_op == LOAD || ex_op == STORE) ? MEM_WAIT : DONE;
                    end
                end
                DONE: begin
                    state    <= IDLE;
                    regwr_en <= (op_q == ALU || op_q == CSR) && (rd_q != '0);
                    branch   <= (op_q == ECALL || op_q == EBREAK || op_q == MRET);
                end
                MEM_WAIT: begin
                    if (mem_fin) begin
                        state    <= IDLE;
                        regwr_en <= (op_q == LOAD) && (rd_q != '0);
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Instruction hold and write-back payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= ex_op;
            pc_q     <= ex_pc;
            rd_q     <= ex_rd;
            addr_q   <= ex_addr;
            data_q   <= ex_data;
            funct3_q <= ex_funct3;
        end
        regwr_sel <= rd_q;
        if (state == DONE) begin
            regwr_data    <= (op_q == CSR) ? csr_rdata : data_q;
            branch_target <= (op_q == MRET) ? mepc_value : mtvec_value;
        end else if (state == MEM_WAIT && ld_done) begin
            regwr_data <= ld_data;
        end
    end

endmodule

// File: design/writeback/csr_file.sv
/* Machine CSRs only, direct-mode mtvec. mip reads zero, minstret is read-only,
   unknown addresses read zero and drop writes. */
`timescale 1ns/10ps

module csr_file import wb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      csr_en,
    input  csr_addr_t csr_addr,
    input  csr_op_e   csr_op,
    input  word_t     csr_operand,
    output word_t     csr_rdata,
    input  logic      trap_ecall,
    input  logic      trap_ebreak,
    input  logic      trap_mret,
    input  word_t     trap_pc,
    input  logic      retire,
    output word_t     mtvec_value,
    output word_t     mepc_value
);

    // msie, mtie, meie positions
    localparam word_t IRQ_BITS = 32'h0000_0888;

    logic  mstatus_mie;
    logic  mstatus_mpie;
    word_t mie_q;
    word_t mtvec_q;
    word_t mscratch_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mtval_q;
    word_t minstret_q;
    word_t wr_value;

    assign mtvec_value = mtvec_q;
    assign mepc_value  = mepc_q;

    // ========================================================================
    // Read side
    // ========================================================================
    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            MSTATUS: begin
                csr_rdata[3]     = mstatus_mie;
                csr_rdata[7]     = mstatus_mpie;
                csr_rdata[12:11] = 2'b11;
            end
            MIE:      csr_rdata = mie_q;
            MTVEC:    csr_rdata = mtvec_q;
            MSCRATCH: csr_rdata = mscratch_q;
            MEPC:     csr_rdata = mepc_q;
            MCAUSE:   csr_rdata = mcause_q;
            MTVAL:    csr_rdata = mtval_q;
            MINSTRET: csr_rdata = minstret_q;
            default:  csr_rdata = '0;
        endcase
    end

    // Write, set or clear against the old value
    always_comb begin
        case (csr_op)
            CSR_RW:  wr_value = csr_operand;
            CSR_RS:  wr_value = csr_rdata | csr_operand;
            CSR_RC:  wr_value = csr_rdata & ~csr_operand;
            default: wr_value = csr_rdata;
        endcase
    end

    // ========================================================================
    // Update side
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec_q      <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mtval_q      <= '0;
            minstret_q   <= '0;
        end else begin
            if (retire) begin
                minstret_q <= minstret_q + 32'd1;
            end

            if (trap_ecall || trap_ebreak) begin
                mepc_q       <= {trap_pc[31:2], 2'b00};
                mcause_q     <= trap_ebreak ? CAUSE_BREAKPOINT : CAUSE_ECALL_M;
                mtval_q      <= trap_ebreak ? trap_pc : '0;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (trap_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end else if (csr_en) begin
                case (csr_addr)
                    MSTATUS: begin
                        mstatus_mie  <= wr_value[3];
                        mstatus_mpie <= wr_value[7];
                    end
                    MIE:      mie_q      <= wr_value & IRQ_BITS;
                    MTVEC:    mtvec_q    <= {wr_value[31:2], 2'b00};
                    MSCRATCH: mscratch_q <= wr_value;
                    MEPC:     mepc_q     <= {wr_value[31:2], 2'b00};
                    MCAUSE:   mcause_q   <= wr_value;
                    MTVAL:    mtval_q    <= wr_value;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: design/writeback/lsu.sv
/* Naturally aligned accesses only; low address bits pick the lane, no misalign traps.
   Bus addresses are word indices. */
`timescale 1ns/10ps

module lsu import wb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_req,
    input  logic       st_req,
    input  word_t      mem_addr,
    input  word_t      mem_wdata,
    input  mem_size_e  mem_size,
    input  logic       ld_unsigned,
    output logic       ld_done,
    output word_t      ld_data,
    output logic       st_done,
    data_bus_if.master bus
);

    logic      rd_pend;
    logic [1:0] off_q;
    mem_size_e size_q;
    logic      unsigned_q;
    word_t     shifted;

    // No new request while a read is outstanding
    assign bus.req   = (ld_req || st_req) && !rd_pend;
    assign bus.we    = st_req;
    assign bus.addr  = {2'b00, mem_addr[31:2]};

    always_comb begin
        case (mem_size)
            BYTE: begin
                bus.mask  = 4'b0001 << mem_addr[1:0];
                bus.wdata = {4{mem_wdata[7:0]}};
            end
            HALF: begin
                bus.mask  = 4'b0011 << {mem_addr[1], 1'b0};
                bus.wdata = {2{mem_wdata[15:0]}};
            end
            default: begin
                bus.mask  = 4'b1111;
                bus.wdata = mem_wdata;
            end
        endcase
    end

    assign st_done = st_req && bus.gnt;
    assign ld_done = rd_pend && bus.rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else if (bus.req && bus.gnt && !bus.we) begin
            rd_pend <= 1'b1;
        end else if (bus.rvalid) begin
            rd_pend <= 1'b0;
        end
    end

    // Lane info for the returning read
    always_ff @(posedge clk) begin
        if (bus.req && bus.gnt && !bus.we) begin
            off_q      <= mem_addr[1:0];
            size_q     <= mem_size;
            unsigned_q <= ld_unsigned;
        end
    end

    assign shifted = bus.rdata >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            BYTE:    ld_data = {{24{shifted[7] && !unsigned_q}}, shifted[7:0]};
            HALF:    ld_data = {{16{shifted[15] && !unsigned_q}}, shifted[15:0]};
            default: ld_data = shifted;
        endcase
    end

endmodule

// File: design/data_arbiter.sv
/* Fixed priority, LSU over host. Only one read may be outstanding;
   its owner is tracked so rvalid goes back to the right master. */
`timescale 1ns/10ps

module data_arbiter (
    input  logic       clk,
    input  logic       rst,
    data_bus_if.slave  lsu_bus,
    data_bus_if.slave  host_bus,
    data_bus_if.master ram_bus
);

    logic sel_lsu;
    logic rd_owner_host;

    assign sel_lsu = lsu_bus.req;

    // Forward the winning payload
    assign ram_bus.req   = lsu_bus.req || host_bus.req;
    assign ram_bus.we    = sel_lsu ? lsu_bus.we    : host_bus.we;
    assign ram_bus.addr  = sel_lsu ? lsu_bus.addr  : host_bus.addr;
    assign ram_bus.wdata = sel_lsu ? lsu_bus.wdata : host_bus.wdata;
    assign ram_bus.mask  = sel_lsu ? lsu_bus.mask  : host_bus.mask;

    assign lsu_bus.gnt  = lsu_bus.req && ram_bus.gnt;
    assign host_bus.gnt = !lsu_bus.req && ram_bus.gnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_owner_host <= 1'b0;
        end else if (ram_bus.req && ram_bus.gnt && !ram_bus.we) begin
            rd_owner_host <= !sel_lsu;
        end
    end

    assign lsu_bus.rdata   = ram_bus.rdata;
    assign host_bus.rdata  = ram_bus.rdata;
    assign lsu_bus.rvalid  = ram_bus.rvalid && !rd_owner_host;
    assign host_bus.rvalid = ram_bus.rvalid && rd_owner_host;

endmodule

// File: design/data_ram.sv
/* Word RAM indexed by the low address bits; RAM_WORDS must be a power of two.
   Every request is granted, read data returns one cycle later. */
`timescale 1ns/10ps

module data_ram import wb_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic      clk,
    data_bus_if.slave bus
);

    localparam int AW = $clog2(RAM_WORDS);

    word_t          mem [RAM_WORDS];
    logic [AW-1:0]  idx;

    assign idx     = bus.addr[AW-1:0];
    assign bus.gnt = 1'b1;

    always_ff @(posedge clk) begin
        if (bus.req && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.mask[i]) mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
        bus.rdata  <= mem[idx];
        bus.rvalid <= bus.req && !bus.we;
    end

endmodule

// File: design/wb_top.sv
/* Write-back end with shared data RAM. host_addr is a word index; the host
   must hold its request while host_ready is low. */
`timescale 1ns/10ps

module wb_top import wb_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ex_valid,
    output logic       ex_ready,
    input  wb_op_e     ex_op,
    input  word_t      ex_pc,
    input  reg_sel_t   ex_rd,
    input  word_t      ex_addr,
    input  word_t      ex_data,
    input  logic [2:0] ex_funct3,
    output logic       regwr_en,
    output reg_sel_t   regwr_sel,
    output word_t      regwr_data,
    output logic       branch,
    output word_t      branch_target,
    input  logic       host_valid,
    output logic       host_ready,
    input  logic       host_we,
    input  word_t      host_addr,
    input  word_t      host_wdata,
    input  byte_mask_t host_mask,
    output word_t      host_rdata,
    output logic       host_rvalid
);

    logic      csr_en;
    csr_addr_t csr_addr;
    csr_op_e   csr_op;
    word_t     csr_operand;
    word_t     csr_rdata;
    logic      trap_ecall;
    logic      trap_ebreak;
    logic      trap_mret;
    word_t     trap_pc;
    logic      retire;
    word_t     mtvec_value;
    word_t     mepc_value;
    logic      ld_req;
    logic      st_req;
    word_t     mem_addr;
    word_t     mem_wdata;
    mem_size_e mem_size;
    logic      ld_unsigned;
    logic      ld_done;
    word_t     ld_data;
    logic      st_done;

    data_bus_if lsu_bus ();
    data_bus_if host_bus ();
    data_bus_if ram_bus ();

    // Host port onto its bus
    assign host_bus.req   = host_valid;
    assign host_bus.we    = host_we;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_bus.mask  = host_mask;
    assign host_ready     = host_bus.gnt;
    assign host_rdata     = host_bus.rdata;
    assign host_rvalid    = host_bus.rvalid;

    wb_stage u_wb_stage (.*);

    csr_file u_csr_file (.*);

    lsu u_lsu (.*, .bus(lsu_bus.master));

    data_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .lsu_bus  (lsu_bus.slave),
        .host_bus (host_bus.slave),
        .ram_bus  (ram_bus.master)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk (clk),
        .bus (ram_bus.slave)
    );

endmodule

// File: dv/tb_wb_top.sv
/* Directed testbench for wb_top with software models of the CSRs and a RAM image.
   Uses host word indices 32..39 only; stops at the first mismatch. */
`timescale 1ns/10ps

module tb_wb_top import wb_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       ex_valid;
    logic       ex_ready;
    wb_op_e     ex_op;
    word_t      ex_pc;
    reg_sel_t   ex_rd;
    word_t      ex_addr;
    word_t      ex_data;
    logic [2:0] ex_funct3;
    logic       regwr_en;
    reg_sel_t   regwr_sel;
    word_t      regwr_data;
    logic       branch;
    word_t      branch_target;
    logic       host_valid;
    logic       host_ready;
    logic       host_we;
    word_t      host_addr;
    word_t      host_wdata;
    byte_mask_t host_mask;
    word_t      host_rdata;
    logic       host_rvalid;

    // Software model state
    word_t m_mstatus;
    word_t m_mie;
    word_t m_mtvec;
    word_t m_mscratch;
    word_t m_mepc;
    word_t m_mcause;
    word_t m_mtval;
    word_t mem_model [0:63];
    int    n_instr;
    word_t pc_next;
    string cur_test;
    int    cycle;
    int    regwr_cycle;
    int    rvalid_cycle;
    logic  host_stalled;

    wb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("CHECK FAILED %s %s: expected 0x%08h actual 0x%08h",
                                        cur_test, what, expected, actual));
        end
    endtask

    // ========================================================================
    // Reference models
    // ========================================================================
    function automatic word_t model_read(input csr_addr_t a);
        case (a)
            MSTATUS:  return m_mstatus;
            MIE:      return m_mie;
            MTVEC:    return m_mtvec;
            MSCRATCH: return m_mscratch;
            MEPC:     return m_mepc;
            MCAUSE:   return m_mcause;
            MTVAL:    return m_mtval;
            MINSTRET: return word_t'(n_instr);
            default:  return '0;
        endcase
    endfunction

    function automatic void model_write(input csr_addr_t a, input csr_op_e op, input word_t v);
        word_t old_val;
        word_t nv;
        old_val = model_read(a);
        case (op)
            CSR_RW:  nv = v;
            CSR_RS:  nv = old_val | v;
            default: nv = old_val & ~v;
        endcase
        case (a)
            MSTATUS:  m_mstatus  = (nv & 32'h88) | 32'h1800;
            MIE:      m_mie      = nv & 32'h888;
            MTVEC:    m_mtvec    = nv & ~32'h3;
            MSCRATCH: m_mscratch = nv;
            MEPC:     m_mepc     = nv & ~32'h3;
            MCAUSE:   m_mcause   = nv;
            MTVAL:    m_mtval    = nv;
            default: ;
        endcase
    endfunction

    function automatic word_t expect_load(input word_t addr, input mem_size_e size,
                                          input logic uns);
        word_t sh;
        sh = mem_model[addr[7:2]] >> (8 * addr[1:0]);
        case (size)
            BYTE:    return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            HALF:    return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    // ========================================================================
    // Bus drivers
    // ========================================================================
    task automatic send(input wb_op_e op, input reg_sel_t rd, input word_t addr,
                        input word_t data, input logic [2:0] f3);
        int waited;
        ex_op     = op;
        ex_pc     = pc_next;
        ex_rd     = rd;
        ex_addr   = addr;
        ex_data   = data;
        ex_funct3 = f3;
        ex_valid  = 1'b1;
        waited    = 0;
        while (!ex_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: ex_ready never rose for issue");
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        pc_next  = pc_next + 4;
        n_instr++;
    endtask

    task automatic host_access(input logic we, input word_t idx, input word_t data,
                               input byte_mask_t mask, output word_t rdata);
        int waited;
        host_valid   = 1'b1;
        host_we      = we;
        host_addr    = idx;
        host_wdata   = data;
        host_mask    = mask;
        host_stalled = !host_ready;
        waited       = 0;
        while (!host_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: host request never granted");
        end
        @(posedge clk);
        #1;
        host_valid = 1'b0;
        rdata      = '0;
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) mem_model[idx[5:0]][8*b +: 8] = data[8*b +: 8];
            end
        end else begin
            waited = 0;
            while (!host_rvalid) begin
                @(posedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) stop_with_failure("Timeout: host read data never came");
            end
            rdata        = host_rdata;
            rvalid_cycle = cycle;
        end
    endtask

    task automatic do_csr(input csr_addr_t a, input logic [2:0] f3, input word_t operand);
        word_t    old_val;
        reg_sel_t rd;
        old_val = model_read(a);
        rd      = 1 + $urandom % 31;
        send(CSR, rd, {20'b0, a}, operand, f3);
        @(posedge clk);
        #1;
        check("csr regwr_en", 1, regwr_en);
        check("csr regwr_sel", rd, regwr_sel);
        check($sformatf("csr 0x%03h old value", a), old_val, regwr_data);
        model_write(a, csr_op_e'(f3[1:0]), operand);
    endtask

    task automatic do_trap(input wb_op_e op);
        word_t    pc;
        word_t    target;
        reg_sel_t rd;
        pc     = pc_next;
        target = (op == MRET) ? m_mepc : m_mtvec;
        rd     = 1 + $urandom % 31;
        send(op, rd, '0, '0, 3'b000);
        @(posedge clk);
        #1;
        check("branch", 1, branch);
        check("branch_target", target, branch_target);
        check("trap regwr_en", 0, regwr_en);
        if (op == MRET) begin
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
        end else begin
            m_mepc       = pc & ~32'h3;
            m_mcause     = (op == EBREAK) ? CAUSE_BREAKPOINT : CAUSE_ECALL_M;
            m_mtval      = (op == EBREAK) ? pc : '0;
            m_mstatus[7] = m_mstatus[3];
            m_mstatus[3] = 1'b0;
        end
        @(posedge clk);
        #1;
        check("branch pulse end", 0, branch);
    endtask

    task automatic do_load(input word_t addr, input mem_size_e size, input logic uns);
        reg_sel_t rd;
        word_t    expected;
        int       waited;
        rd       = 1 + $urandom % 31;
        expected = expect_load(addr, size, uns);
        send(LOAD, rd, addr, '0, {uns, size});
        waited = 0;
        while (!regwr_en) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: load never wrote back");
        end
        regwr_cycle = cycle;
        check("load regwr_sel", rd, regwr_sel);
        check($sformatf("load 0x%0h size %0d u%0d", addr, size, uns), expected, regwr_data);
    endtask

    task automatic do_store(input word_t addr, input mem_size_e size, input word_t data);
        int waited;
        send(STORE, 5'd0, addr, data, {1'b0, size});
        waited = 0;
        while (!ex_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout: store never completed");
        end
        case (size)
            BYTE:    mem_model[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
            HALF:    mem_model[addr[7:2]][16*addr[1] +: 16] = data[15:0];
            default: mem_model[addr[7:2]] = data;
        endcase
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic test_alu();
        reg_sel_t rd;
        word_t    val;
        cur_test = "alu_retire";
        for (int i = 0; i < 10; i++) begin
            rd  = 1 + $urandom % 31;
            val = $urandom;
            send(ALU, rd, '0, val, 3'b000);
            @(posedge clk);
            #1;
            check("regwr_en", 1, regwr_en);
            check("regwr_sel", rd, regwr_sel);
            check("regwr_data", val, regwr_data);
            @(posedge clk);
            #1;
            check("regwr_en pulse end", 0, regwr_en);
        end
        send(ALU, 5'd0, '0, $urandom, 3'b000);
        repeat (8) begin
            @(posedge clk);
            #1;
            check("regwr_en with rd zero", 0, regwr_en);
        end
    endtask

    task automatic test_csr();
        csr_addr_t csrs [0:7] = '{MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP};
        logic [1:0] op;
        logic       imm;
        cur_test = "csr_rmw";
        foreach (csrs[k]) begin
            for (int i = 0; i < 4; i++) begin
                op  = 2'(1 + $urandom % 3);
                imm = $urandom % 2;
                do_csr(csrs[k], {imm, op}, imm ? word_t'($urandom % 32) : word_t'($urandom));
            end
            do_csr(csrs[k], 3'b010, '0);
        end
    endtask

    task automatic test_traps();
        cur_test = "traps";
        do_csr(MTVEC, 3'b001, 32'h0000_2a40);
        do_csr(MSTATUS, 3'b001, 32'h8);
        do_trap(ECALL);
        do_csr(MEPC, 3'b010, '0);
        do_csr(MCAUSE, 3'b010, '0);
        do_csr(MTVAL, 3'b010, '0);
        do_csr(MSTATUS, 3'b010, '0);
        do_trap(EBREAK);
        do_csr(MEPC, 3'b010, '0);
        do_csr(MCAUSE, 3'b010, '0);
        do_csr(MTVAL, 3'b010, '0);
        do_trap(MRET);
        do_csr(MSTATUS, 3'b010, '0);
        check("mstatus.mie after mret", 0, regwr_data[3]);
        check("mstatus.mpie after mret", 1, regwr_data[7]);
    endtask

    task automatic test_mem();
        word_t rdata;
        cur_test = "load_store";
        for (int w = 32; w < 40; w++) begin
            host_access(1'b1, w, $urandom, 4'hf, rdata);
        end
        for (int i = 0; i < 4; i++) begin
            do_store(32'd128 + i, BYTE, $urandom);
        end
        do_store(32'd136, HALF, $urandom);
        do_store(32'd138, HALF, $urandom);
        do_store(32'd140, WORD, $urandom);
        do_store(32'd147, BYTE, $urandom);
        do_store(32'd150, HALF, $urandom);
        for (int a = 128; a < 160; a++) begin
            do_load(a, BYTE, 1'b0);
            do_load(a, BYTE, 1'b1);
            if (a % 2 == 0) begin
                do_load(a, HALF, 1'b0);
                do_load(a, HALF, 1'b1);
            end
            if (a % 4 == 0) do_load(a, WORD, 1'b0);
        end
        for (int w = 32; w < 40; w++) begin
            host_access(1'b0, w, '0, 4'h0, rdata);
            check($sformatf("host read-back word %0d", w), mem_model[w], rdata);
        end
    endtask

    task automatic test_sharing();
        word_t rdata;
        cur_test = "sharing";
        fork
            do_load(32'd134, HALF, 1'b0);
            begin
                @(posedge clk);
                #1;
                host_access(1'b0, 32'd37, '0, 4'h0, rdata);
            end
        join
        check("host read during load", mem_model[37], rdata);
        check("host held off by load", 1, host_stalled);
        check("host done after load grant", 1, rvalid_cycle >= regwr_cycle);
    endtask

    task automatic test_minstret();
        cur_test = "minstret";
        do_csr(MINSTRET, 3'b010, '0);
    endtask

    initial begin
        void'($urandom(91953));
        rst        = 1'b1;
        ex_valid   = 1'b0;
        ex_op      = ALU;
        ex_pc      = '0;
        ex_rd      = '0;
        ex_addr    = '0;
        ex_data    = '0;
        ex_funct3  = '0;
        host_valid = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_mask  = '0;
        m_mstatus  = 32'h1800;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        n_instr    = 0;
        pc_next    = 32'h0000_0100;
        cycle      = 0;
        cur_test   = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check("ex_ready", 1, ex_ready);
        check("regwr_en", 0, regwr_en);
        check("branch", 0, branch);
        check("host_rvalid", 0, host_rvalid);
        test_alu();
        test_csr();
        test_traps();
        test_mem();
        test_sharing();
        test_minstret();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: build.f
common/wb_pkg.sv
common/data_bus_if.sv
design/writeback/wb_stage.sv
design/writeback/csr_file.sv
design/writeback/lsu.sv
design/data_arbiter.sv
design/data_ram.sv
design/wb_top.sv
dv/tb_wb_top.sv
